// File: hw/ipdc_op_pkg.sv
package ipdc_op_pkg;

	// host operation codes
	typedef enum logic [3:0] {
		LOAD        = 4'b0000,
		SHIFT_RIGHT = 4'b0100,
		SHIFT_LEFT  = 4'b0101,
		SHIFT_UP    = 4'b0110,
		SHIFT_DOWN  = 4'b0111,
		YCBCR       = 4'b1101
	} op_mode_t;

	// which path feeds the output register
	typedef enum logic {
		SRC_RGB,
		SRC_YCBCR
	} out_src_t;

	// controller states
	typedef enum logic [2:0] {
		S_IDLE,
		S_READY,
		S_WAIT_OP,
		S_LOAD,
		S_READ,
		S_SHOW
	} ctrl_state_t;

endpackage

// File: hw/ipdc_pix_pkg.sv
package ipdc_pix_pkg;

	// one colour channel
	typedef logic [7:0] channel_t;

	// also carries Y, Cb, Cr in the r, g, b slots
	typedef struct packed {
		channel_t r;
		channel_t g;
		channel_t b;
	} rgb_t;

	// row in [7:4], column in [3:0]
	typedef logic [7:0] pix_addr_t;

	// row or column index
	typedef logic [3:0] coord_t;

	localparam int IMG_SIDE   = 16;
	localparam int IMG_PIXELS = IMG_SIDE * IMG_SIDE;

endpackage

// File: hw/frame_buffer.sv
module frame_buffer #(
	parameter int DEPTH = ipdc_pix_pkg::IMG_PIXELS
) (
	input  logic                    i_clk,
	input  logic                    i_we,
	input  ipdc_pix_pkg::pix_addr_t i_addr,
	input  ipdc_pix_pkg::rgb_t      i_d,
	output ipdc_pix_pkg::rgb_t      o_q
);
	import ipdc_pix_pkg::*;

	// one plane per colour, shared address and write enable
	channel_t plane_r [DEPTH];
	channel_t plane_g [DEPTH];
	channel_t plane_b [DEPTH];

	always_ff @(posedge i_clk) begin
		if (i_we) begin
			plane_r[i_addr] <= i_d.r;
			plane_g[i_addr] <= i_d.g;
			plane_b[i_addr] <= i_d.b;
		end
		// registered read, old data on a same-cycle write
		o_q.r <= plane_r[i_addr];
		o_q.g <= plane_g[i_addr];
		o_q.b <= plane_b[i_addr];
	end

	a_write_in_range: assert property (
		@(posedge i_clk) i_we |-> (int'(i_addr) < DEPTH)
	);

endmodule

// File: hw/window_ctrl.sv
module window_ctrl #(
	parameter int WIN_SIDE = 4
) (
	input  logic                    i_clk,
	input  logic                    i_rst_n,
	input  logic                    i_op_valid,
	input  ipdc_op_pkg::op_mode_t   i_op_mode,
	input  logic                    i_in_valid,
	output logic                    o_op_ready,
	output logic                    o_in_ready,
	output logic                    o_out_valid,
	output ipdc_pix_pkg::pix_addr_t o_mem_addr,
	output logic                    o_mem_we,
	output ipdc_op_pkg::out_src_t   o_out_src
);
	import ipdc_op_pkg::*;
	import ipdc_pix_pkg::*;

	// largest origin that keeps the window inside the image
	localparam coord_t ORG_MAX  = coord_t'(IMG_SIDE - WIN_SIDE);
	localparam coord_t WIN_LAST = coord_t'(WIN_SIDE - 1);

	ctrl_state_t state;
	ctrl_state_t state_nxt;
	coord_t      org_row;
	coord_t      org_col;
	coord_t      scan_row;
	coord_t      scan_col;
	pix_addr_t   load_cnt;
	pix_addr_t   win_addr;
	out_src_t    src_r;
	logic        op_ready_r;
	logic        out_valid_r;
	logic        op_take;
	logic        scan_last;

	assign op_take   = (state == S_WAIT_OP) && i_op_valid;
	assign scan_last = (scan_row == WIN_LAST) && (scan_col == WIN_LAST);

	// ------------------------------------------------------------
	// state machine
	// ------------------------------------------------------------
	always_comb begin
		state_nxt = state;
		case (state)
			S_IDLE:    state_nxt = S_READY;
			S_READY:   state_nxt = S_WAIT_OP;
			S_WAIT_OP: begin
				if (i_op_valid) begin
					case (i_op_mode)
						LOAD:        state_nxt = S_LOAD;
						SHIFT_RIGHT,
						SHIFT_LEFT,
						SHIFT_UP,
						SHIFT_DOWN,
						YCBCR:       state_nxt = S_READ;
						// unknown code asks again
						default:     state_nxt = S_READY;
					endcase
				end
			end
			S_LOAD: begin
				if (i_in_valid && load_cnt == pix_addr_t'(IMG_PIXELS - 1))
					state_nxt = S_READY;
			end
			S_READ:    state_nxt = S_SHOW;
			S_SHOW:    state_nxt = scan_last ? S_READY : S_READ;
			default:   state_nxt = S_IDLE;
		endcase
	end

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state       <= S_IDLE;
			op_ready_r  <= 1'b0;
			out_valid_r <= 1'b0;
		end else begin
			state       <= state_nxt;
			op_ready_r  <= (state == S_READY);
			// data for a SHOW cycle lands in the output register on this edge too
			out_valid_r <= (state == S_SHOW);
		end
	end

	// ------------------------------------------------------------
	// origin and source select
	// ------------------------------------------------------------
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			org_row <= '0;
			org_col <= '0;
			src_r   <= SRC_RGB;
		end else if (op_take) begin
			src_r <= (i_op_mode == YCBCR) ? SRC_YCBCR : SRC_RGB;
			case (i_op_mode)
				SHIFT_RIGHT: if (org_col < ORG_MAX) org_col <= org_col + coord_t'(1);
				SHIFT_LEFT:  if (org_col != '0)     org_col <= org_col - coord_t'(1);
				SHIFT_UP:    if (org_row != '0)     org_row <= org_row - coord_t'(1);
				SHIFT_DOWN:  if (org_row < ORG_MAX) org_row <= org_row + coord_t'(1);
				default:     ;
			endcase
		end
	end

	// ------------------------------------------------------------
	// load and scan counters
	// ------------------------------------------------------------
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			load_cnt <= '0;
			scan_row <= '0;
			scan_col <= '0;
		end else begin
			// wraps back to 0 after the last pixel
			if (state == S_LOAD && i_in_valid)
				load_cnt <= load_cnt + pix_addr_t'(1);
			if (state == S_SHOW) begin
				if (scan_col == WIN_LAST) begin
					scan_col <= '0;
					scan_row <= scan_last ? coord_t'(0) : scan_row + coord_t'(1);
				end else begin
					scan_col <= scan_col + coord_t'(1);
				end
			end
		end
	end

	// origin + 16 * row + col
	assign win_addr = {org_row, org_col} + pix_addr_t'({scan_row, 4'b0000})
		+ pix_addr_t'(scan_col);

	assign o_mem_addr  = (state == S_LOAD) ? load_cnt : win_addr;
	assign o_mem_we    = (state == S_LOAD) && i_in_valid;
	assign o_in_ready  = (state == S_LOAD);
	assign o_op_ready  = op_ready_r;
	assign o_out_valid = out_valid_r;
	assign o_out_src   = src_r;

	a_origin_in_range: assert property (
		@(posedge i_clk) disable iff (!i_rst_n)
		(org_row <= ORG_MAX) && (org_col <= ORG_MAX)
	);

	// no pixel in the op-ready cycle or the two cycles after it
	a_strobes_apart: assert property (
		@(posedge i_clk) disable iff (!i_rst_n)
		o_out_valid |-> !o_op_ready && !$past(o_op_ready) && !$past(o_op_ready, 2)
	);

	// a write needs a taken LOAD code or a load already under way
	a_write_only_in_load: assert property (
		@(posedge i_clk) disable iff (!i_rst_n)
		o_mem_we |-> $past(state == S_LOAD) || $past(op_take && i_op_mode == LOAD)
	);

endmodule

// File: hw/ycbcr_convert.sv
module ycbcr_convert (
	input  ipdc_pix_pkg::rgb_t i_rgb,
	output ipdc_pix_pkg::rgb_t o_ycc
);
	import ipdc_pix_pkg::*;

	// eighths back to a channel, halves round up
	function automatic channel_t round_clamp(input logic signed [12:0] s8);
		logic signed [12:0] q;
		q = (s8 + 13'sd4) >>> 3;
		if (q < 0)
			return '0;
		else if (q > 13'sd255)
			return 8'hff;
		else
			return channel_t'(q[7:0]);
	endfunction

	logic signed [12:0] r_s;
	logic signed [12:0] g_s;
	logic signed [12:0] b_s;
	logic signed [12:0] y8;
	logic signed [12:0] cb8;
	logic signed [12:0] cr8;

	assign r_s = $signed({5'b00000, i_rgb.r});
	assign g_s = $signed({5'b00000, i_rgb.g});
	assign b_s = $signed({5'b00000, i_rgb.b});

	// 8Y = 2R + 5G
	assign y8  = (r_s <<< 1) + (g_s <<< 2) + g_s;
	// 8Cb = -R - 2G + 4B + 1024
	assign cb8 = (b_s <<< 2) - r_s - (g_s <<< 1) + 13'sd1024;
	// 8Cr = 4R - 3G - B + 1024
	assign cr8 = (r_s <<< 2) - (g_s <<< 1) - g_s - b_s + 13'sd1024;

	assign o_ycc.r = round_clamp(y8);
	assign o_ycc.g = round_clamp(cb8);
	assign o_ycc.b = round_clamp(cr8);

endmodule

// File: hw/ipdc.sv
module ipdc #(
	parameter int WIN_SIDE = 4,
	parameter int DEPTH    = ipdc_pix_pkg::IMG_PIXELS
) (
	input  logic                  i_clk,
	input  logic                  i_rst_n,
	input  logic                  i_op_valid,
	input  ipdc_op_pkg::op_mode_t i_op_mode,
	output logic                  o_op_ready,
	input  logic                  i_in_valid,
	input  ipdc_pix_pkg::rgb_t    i_in_data,
	output logic                  o_in_ready,
	output logic                  o_out_valid,
	output ipdc_pix_pkg::rgb_t    o_out_data
);
	import ipdc_op_pkg::*;
	import ipdc_pix_pkg::*;

	pix_addr_t mem_addr;
	logic      mem_we;
	out_src_t  out_src;
	rgb_t      mem_q;
	rgb_t      ycc;
	rgb_t      sel_data;

	window_ctrl #(
		.WIN_SIDE (WIN_SIDE)
	) u_ctrl (
		.i_clk       (i_clk),
		.i_rst_n     (i_rst_n),
		.i_op_valid  (i_op_valid),
		.i_op_mode   (i_op_mode),
		.i_in_valid  (i_in_valid),
		.o_op_ready  (o_op_ready),
		.o_in_ready  (o_in_ready),
		.o_out_valid (o_out_valid),
		.o_mem_addr  (mem_addr),
		.o_mem_we    (mem_we),
		.o_out_src   (out_src)
	);

	frame_buffer #(
		.DEPTH (DEPTH)
	) u_fb (
		.i_clk  (i_clk),
		.i_we   (mem_we),
		.i_addr (mem_addr),
		.i_d    (i_in_data),
		.o_q    (mem_q)
	);

	ycbcr_convert u_ycc (
		.i_rgb (mem_q),
		.o_ycc (ycc)
	);

	// ------------------------------------------------------------
	// output select and register
	// ------------------------------------------------------------
	always_comb begin
		case (out_src)
			SRC_YCBCR: sel_data = ycc;
			default:   sel_data = mem_q;
		endcase
	end

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n)
			o_out_data <= '0;
		else
			o_out_data <= sel_data;
	end

endmodule

// File: bench/tb_ipdc.sv
module tb_ipdc;
	timeunit 1ns;
	timeprecision 1ps;

	import ipdc_op_pkg::*;
	import ipdc_pix_pkg::*;

	localparam int WIN_SIDE  = 4;
	localparam int WIN_PIX   = WIN_SIDE * WIN_SIDE;
	localparam int ORG_LIMIT = IMG_SIDE - WIN_SIDE;
	localparam int MAX_WORDS = 512;
	// generous bound on the cycles of one operation
	localparam int OP_CYCLES = 2 * WIN_PIX + 8;
	localparam logic [23:0] END_MARK = 24'hffffff;

	logic        clk = 1'b0;
	logic        rst_n;
	logic        op_valid;
	op_mode_t    op_mode;
	logic        op_ready;
	logic        in_valid;
	rgb_t        in_data;
	logic        in_ready;
	logic        out_valid;
	rgb_t        out_data;

	// image words first, then one word per operation
	logic [23:0] stim [MAX_WORDS];
	rgb_t        ref_img [IMG_PIXELS];
	rgb_t        expect_q [$];
	int          ref_row;
	int          ref_col;
	int          n_ops;
	int          seed;
	int          cycle = 0;
	int          cycle_limit = 0;

	ipdc #(
		.WIN_SIDE (WIN_SIDE),
		.DEPTH    (IMG_PIXELS)
	) uut (
		.i_clk       (clk),
		.i_rst_n     (rst_n),
		.i_op_valid  (op_valid),
		.i_op_mode   (op_mode),
		.o_op_ready  (op_ready),
		.i_in_valid  (in_valid),
		.i_in_data   (in_data),
		.o_in_ready  (in_ready),
		.o_out_valid (out_valid),
		.o_out_data  (out_data)
	);

	always #10 clk = ~clk;

	task automatic stop_with_error(input string line);
		$display("%s", line);
		$display("Done: errors found");
		$fatal(1);
	endtask

	always @(posedge clk) begin
		cycle = cycle + 1;
		if (cycle_limit > 0 && cycle > cycle_limit)
			stop_with_error($sformatf("timeout: the run did not finish within %0d cycles",
				cycle_limit));
	end

	// ------------------------------------------------------------
	// reference model
	// ------------------------------------------------------------
	function automatic channel_t to_channel(input real x);
		int v;
		v = int'($floor(x + 0.5));
		if (v < 0)
			v = 0;
		if (v > 255)
			v = 255;
		return channel_t'(v);
	endfunction

	function automatic rgb_t to_ycbcr(input rgb_t p);
		real  rr;
		real  gg;
		real  bb;
		rgb_t q;
		rr = p.r;
		gg = p.g;
		bb = p.b;
		q.r = to_channel(0.25 * rr + 0.625 * gg);
		q.g = to_channel(-0.125 * rr - 0.25 * gg + 0.5 * bb + 128.0);
		q.b = to_channel(0.5 * rr - 0.375 * gg - 0.125 * bb + 128.0);
		return q;
	endfunction

	task automatic move_origin(input op_mode_t code);
		case (code)
			SHIFT_RIGHT: if (ref_col < ORG_LIMIT) ref_col++;
			SHIFT_LEFT:  if (ref_col > 0) ref_col--;
			SHIFT_UP:    if (ref_row > 0) ref_row--;
			SHIFT_DOWN:  if (ref_row < ORG_LIMIT) ref_row++;
			default:     ;
		endcase
	endtask

	task automatic expect_window(input op_mode_t code);
		int   r;
		int   c;
		rgb_t p;
		expect_q.delete();
		if (code inside {SHIFT_RIGHT, SHIFT_LEFT, SHIFT_UP, SHIFT_DOWN, YCBCR}) begin
			for (r = 0; r < WIN_SIDE; r++) begin
				for (c = 0; c < WIN_SIDE; c++) begin
					p = ref_img[(ref_row + r) * IMG_SIDE + ref_col + c];
					expect_q.push_back((code == YCBCR) ? to_ycbcr(p) : p);
				end
			end
		end
	endtask

	// ------------------------------------------------------------
	// host side
	// ------------------------------------------------------------
	task automatic wait_op_ready();
		@(posedge clk);
		while (!op_ready) begin
			assert (!out_valid && !in_ready) else
				stop_with_error("out-valid or in-ready went high before the first operation");
			@(posedge clk);
		end
	endtask

	// called at the edge where op-ready was seen, returns at the next one
	task automatic run_op(input logic [23:0] word);
		op_mode_t code;
		int       k;
		int       pix_idx;
		int       got_cnt;
		int       want_cnt;
		rgb_t     want;
		code = op_mode_t'(word[11:8]);
		if (code == LOAD) begin
			for (k = 0; k < IMG_PIXELS; k++)
				ref_img[k] = stim[k];
		end
		move_origin(code);
		assert (ref_row == int'(word[7:4]) && ref_col == int'(word[3:0])) else
			stop_with_error($sformatf("model origin %0d,%0d does not match data file word %h",
				ref_row, ref_col, word));
		expect_window(code);
		want_cnt = expect_q.size();
		pix_idx  = 0;
		got_cnt  = 0;

		op_valid <= 1'b1;
		op_mode  <= code;
		@(posedge clk);
		op_valid <= 1'b0;
		while (!op_ready) begin
			in_valid <= 1'b0;
			if (in_ready) begin
				assert (code == LOAD) else
					stop_with_error($sformatf("in-ready went high during op %h", word[11:8]));
				// random pauses in the pixel stream
				if (pix_idx < IMG_PIXELS && ($random(seed) & 3) != 0) begin
					in_valid <= 1'b1;
					in_data  <= stim[pix_idx];
					pix_idx++;
				end
			end
			if (out_valid) begin
				assert (expect_q.size() > 0) else
					stop_with_error($sformatf("op %h sent a pixel that was not expected",
						word[11:8]));
				want = expect_q.pop_front();
				assert (out_data == want) else
					stop_with_error($sformatf("** Error (%0t): op %h pixel %0d expected %h, got %h",
						$time, word[11:8], got_cnt, want, out_data));
				got_cnt++;
			end
			@(posedge clk);
		end
		in_valid <= 1'b0;

		assert (got_cnt == want_cnt) else
			stop_with_error($sformatf("op %h sent %0d pixels instead of %0d",
				word[11:8], got_cnt, want_cnt));
		if (code == LOAD) begin
			assert (pix_idx == IMG_PIXELS) else
				stop_with_error($sformatf("load finished after only %0d pixels", pix_idx));
		end
	endtask

	initial begin
		int k;
		rst_n    = 1'b0;
		op_valid = 1'b0;
		op_mode  = LOAD;
		in_valid = 1'b0;
		in_data  = '0;
		seed     = 94;
		ref_row  = 0;
		ref_col  = 0;
		for (k = 0; k < IMG_PIXELS; k++)
			ref_img[k] = '0;

		// unfilled words keep the end mark
		for (k = 0; k < MAX_WORDS; k++)
			stim[k] = END_MARK;
		$readmemh("bench/ipdc_testdata.txt", stim);
		n_ops = 0;
		while (IMG_PIXELS + n_ops < MAX_WORDS && stim[IMG_PIXELS + n_ops] != END_MARK)
			n_ops++;
		assert (n_ops > 0) else
			stop_with_error("the data file holds no operations");
		cycle_limit = 20 * (IMG_PIXELS + n_ops * OP_CYCLES);

		repeat (16) @(posedge clk);
		assert (!op_ready && !out_valid && !in_ready && out_data == '0) else
			stop_with_error("outputs are not cleared during reset");
		rst_n <= 1'b1;

		wait_op_ready();
		for (k = 0; k < n_ops; k++)
			run_op(stim[IMG_PIXELS + k]);

		$display("Done: no errors");
		$finish;
	end

endmodule

// File: bench/ipdc_testdata.txt
// 16 image rows of 16 pixels rrggbb, raster order
// then operations: op code, expected origin row, expected origin col
ffffff 000000 0220fd 0330fc 0440fb 0550fa 0660f9 0770f8 0880f7 0990f6 0aa0f5 0bb0f4 0cc0f3 0dd0f2 0ee0f1 0ff0f0
1001ef ff0000 00ffff 1331ec 1441eb 1551ea 1661e9 1771e8 1881e7 1991e6 1aa1e5 1bb1e4 1cc1e3 1dd1e2 1ee1e1 1ff1e0
2002df 2112de 00ff00 2332dc 2442db 2552da 2662d9 2772d8 2882d7 2992d6 2aa2d5 2bb2d4 2cc2d3 2dd2d2 2ee2d1 2ff2d0
3003cf 3113ce 3223cd 0000ff 3443cb 3553ca 3663c9 3773c8 3883c7 3993c6 3aa3c5 3bb3c4 3cc3c3 3dd3c2 3ee3c1 3ff3c0
4004bf 4114be 4224bd 4334bc 4444bb 4554ba 4664b9 4774b8 4884b7 4994b6 4aa4b5 4bb4b4 4cc4b3 4dd4b2 4ee4b1 4ff4b0
5005af 5115ae 5225ad 5335ac 5445ab 5555aa 5665a9 5775a8 5885a7 5995a6 5aa5a5 5bb5a4 5cc5a3 5dd5a2 5ee5a1 5ff5a0
60069f 61169e 62269d 63369c 64469b 65569a 666699 677698 688697 699696 6aa695 6bb694 6cc693 6dd692 6ee691 6ff690
70078f 71178e 72278d 73378c 74478b 75578a 766789 777788 788787 799786 7aa785 7bb784 7cc783 7dd782 7ee781 7ff780
80087f 81187e 82287d 83387c 84487b 85587a 866879 877878 888877 899876 8aa875 8bb874 8cc873 8dd872 8ee871 8ff870
90096f 91196e 92296d 93396c 94496b 95596a 966969 977968 988967 999966 9aa965 9bb964 9cc963 9dd962 9ee961 9ff960
a00a5f a11a5e a22a5d a33a5c a44a5b a55a5a a66a59 a77a58 a88a57 a99a56 aaaa55 abba54 acca53 adda52 aeea51 affa50
b00b4f b11b4e b22b4d b33b4c b44b4b b55b4a b66b49 b77b48 b88b47 b99b46 baab45 bbbb44 bccb43 bddb42 beeb41 bffb40
c00c3f c11c3e c22c3d c33c3c c44c3b c55c3a c66c39 c77c38 c88c37 c99c36 caac35 cbbc34 ffffff cddc32 ceec31 cffc30
d00d2f d11d2e d22d2d d33d2c d44d2b d55d2a d66d29 d77d28 d88d27 d99d26 daad25 dbbd24 dccd23 000000 deed21 dffd20
e00e1f e11e1e e22e1d e33e1c e44e1b e55e1a e66e19 e77e18 e88e17 e99e16 eaae15 ebbe14 ecce13 edde12 ff0000 effe10
f00f0f f11f0e f22f0d f33f0c f44f0b f55f0a f66f09 f77f08 f88f07 f99f06 faaf05 fbbf04 00ff00 fddf02 feef01 0000ff
// load, left at the edge, colour conversion of the top-left window
000 500 d00
// right up to the limit and past it
401 402 403 404 405 406 407 408 409 40a 40b 40c 40c 40c
// down up to the limit and past it
71c 72c 73c 74c 75c 76c 77c 78c 79c 7ac 7bc 7cc 7cc
// colour conversion of the bottom-right window, then unused codes
dcc fcc 8cc 1cc
// back up
6bc 6ac 69c 68c 67c 66c 65c 64c 63c 62c 61c 60c 60c
// back left
50b 50a 509 508 507 506 505 504 503 502 501 500 500
// a few mixed moves
710 d10 411 d11 311

// File: sources.f
hw/ipdc_op_pkg.sv
hw/ipdc_pix_pkg.sv
hw/frame_buffer.sv
hw/window_ctrl.sv
hw/ycbcr_convert.sv
hw/ipdc.sv
bench/tb_ipdc.sv

// File: Makefile
# Verilator build and run of the ipdc testbench

SRCS := $(shell grep -v '^+' sources.f)

obj_dir/Vtb_ipdc: sources.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_ipdc -f sources.f

.PHONY: run clean

# pass only if the testbench printed its pass line
run: obj_dir/Vtb_ipdc bench/ipdc_testdata.txt
	@out="$$(./obj_dir/Vtb_ipdc)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Done: no errors"

clean:
	rm -rf obj_dir
